/* obi_subsys_top.f */
common/obi_pkg.sv
obi_mem/obi_mem.sv
obi_mem/obi_mem_cfg.sv
source/obi_host_bridge.sv
source/obi_subsys_top.sv
dv/tb_clock_gen.sv
dv/obi_subsys_tb.sv

/* Makefile */
BUILD_DIR := build

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module obi_subsys_tb -f obi_subsys_top.f \
		--Mdir $(BUILD_DIR) -o obi_subsys_sim
	@out="$$(./$(BUILD_DIR)/obi_subsys_sim)"; echo "$$out"; \
		echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(BUILD_DIR)

/* dv/obi_subsys_tb.sv */
`timescale 1ns/1ps

module obi_subsys_tb;

    import obi_pkg::*;

    localparam int clk_period_ns     = 40;
    localparam int random_seed       = 41802;
    localparam int max_release_delay = 6;
    localparam int num_random_cmds   = 200;
    // Ack at both waits of 7, then the release delay, the fall and the idle gap
    localparam int worst_transfer_cycles = 3 + 2 * wait_max + max_release_delay + 6;
    // Directed transfers, then each random command with a wait update every fourth
    localparam int transfer_bound        = 60 + num_random_cmds + num_random_cmds / 2;
    localparam int timeout_cycles        = transfer_bound * worst_transfer_cycles + 1000;

    logic                      clk;
    logic                      rst_n;
    logic                      cmd_req_i;
    logic [addr_width-1:0]     cmd_addr_i;
    logic                      cmd_we_i;
    logic [be_width-1:0]       cmd_be_i;
    logic [data_width-1:0]     cmd_wdata_i;
    logic                      cmd_ack_o;
    logic [data_width-1:0]     cmd_rdata_o;
    logic                      cfg_req_i;
    logic                      cfg_we_i;
    logic [cfg_addr_width-1:0] cfg_addr_i;
    logic [wait_width-1:0]     cfg_wdata_i;
    logic                      cfg_ack_o;
    logic [wait_width-1:0]     cfg_rdata_o;

    int error_count;
    int test_count;
    int transfer_count;
    int test_errors_start;
    int exp_gnt_wait;
    int exp_rvalid_wait;
    int exp_latency;
    int ack_latency;

    logic [data_width-1:0] ref_mem   [mem_words];
    logic [be_width-1:0]   ref_known [mem_words];
    logic [data_width-1:0] exp_cmd_rdata;
    logic [data_width-1:0] exp_cmd_mask;
    logic [wait_width-1:0] exp_cfg_rdata;

    tb_clock_gen #(.period_ns(clk_period_ns), .reset_cycles(8)) clock_gen_inst (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    obi_subsys_top obi_subsys_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_req_i   (cmd_req_i),
        .cmd_addr_i  (cmd_addr_i),
        .cmd_we_i    (cmd_we_i),
        .cmd_be_i    (cmd_be_i),
        .cmd_wdata_i (cmd_wdata_i),
        .cmd_ack_o   (cmd_ack_o),
        .cmd_rdata_o (cmd_rdata_o),
        .cfg_req_i   (cfg_req_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_ack_o   (cfg_ack_o),
        .cfg_rdata_o (cfg_rdata_o)
    );

    function automatic logic [data_width-1:0] apply_byte_enables(
        input logic [data_width-1:0] old_word,
        input logic [data_width-1:0] wdata,
        input logic [be_width-1:0]   be
    );
        logic [data_width-1:0] word;
        word = old_word;
        for (int b = 0; b < be_width; b++) begin
            if (be[b]) begin
                word[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return word;
    endfunction

    function automatic logic [data_width-1:0] known_bytes_mask(input logic [be_width-1:0] known);
        logic [data_width-1:0] mask;
        for (int b = 0; b < be_width; b++) begin
            mask[b*8 +: 8] = {8{known[b]}};
        end
        return mask;
    endfunction

    task automatic report_mismatch(input string name, input logic [data_width-1:0] expected,
                                   input logic [data_width-1:0] actual);
        $display("ERROR: %s expected 0x%h, got 0x%h", name, expected, actual);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("Check failed: %s", what);
        error_count++;
    endtask

    task automatic run_command(input logic [addr_width-1:0] addr, input logic we,
                               input logic [be_width-1:0] be, input logic [data_width-1:0] wdata,
                               input int release_delay);
        logic [mem_index_width-1:0] idx;
        // Bits above 9 are ignored, so higher addresses alias
        idx           = addr[9:2];
        exp_cmd_rdata = ref_mem[idx];
        exp_cmd_mask  = known_bytes_mask(ref_known[idx]);
        exp_latency   = 3 + exp_gnt_wait + exp_rvalid_wait;
        // One idle cycle lets the bridge leave its release state
        @(negedge clk);
        cmd_addr_i  = addr;
        cmd_we_i    = we;
        cmd_be_i    = be;
        cmd_wdata_i = wdata;
        cmd_req_i   = 1'b1;
        @(negedge clk);
        while (!cmd_ack_o) begin
            @(negedge clk);
        end
        repeat (release_delay) @(negedge clk);
        cmd_req_i = 1'b0;
        @(negedge clk);
        while (cmd_ack_o) begin
            @(negedge clk);
        end
        if (we) begin
            ref_mem[idx]   = apply_byte_enables(ref_mem[idx], wdata, be);
            ref_known[idx] = ref_known[idx] | be;
        end
        transfer_count++;
    endtask

    task automatic run_cfg(input logic we, input logic [cfg_addr_width-1:0] addr,
                           input logic [wait_width-1:0] wdata, input int release_delay);
        exp_cfg_rdata = (addr == cfg_addr_gnt_wait) ? exp_gnt_wait[wait_width-1:0]
                                                    : exp_rvalid_wait[wait_width-1:0];
        @(negedge clk);
        cfg_we_i    = we;
        cfg_addr_i  = addr;
        cfg_wdata_i = wdata;
        cfg_req_i   = 1'b1;
        @(negedge clk);
        while (!cfg_ack_o) begin
            @(negedge clk);
        end
        repeat (release_delay) @(negedge clk);
        cfg_req_i = 1'b0;
        @(negedge clk);
        while (cfg_ack_o) begin
            @(negedge clk);
        end
        if (we && addr == cfg_addr_gnt_wait) begin
            exp_gnt_wait = int'(wdata);
        end else if (we) begin
            exp_rvalid_wait = int'(wdata);
        end
        transfer_count++;
    endtask

    task automatic exercise_waits(input logic [wait_width-1:0] gnt,
                                  input logic [wait_width-1:0] rvalid);
        run_cfg(1'b1, cfg_addr_gnt_wait, gnt, 0);
        run_cfg(1'b1, cfg_addr_rvalid_wait, rvalid, 0);
        run_cfg(1'b0, cfg_addr_gnt_wait, '0, 0);
        run_cfg(1'b0, cfg_addr_rvalid_wait, '0, 0);
        run_command(32'h0000_0100, 1'b1, 4'hf, {29'd0, gnt} ^ 32'h5a5a_0000, 0);
        run_command(32'h0000_0100, 1'b0, 4'h0, 32'h0, 0);
    endtask

    task automatic run_random_commands(input int count);
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
        int unsigned           rnd;
        int                    delay;
        for (int i = 0; i < count; i++) begin
            if (i % 4 == 0) begin
                rnd = $urandom_range(0, wait_max);
                run_cfg(1'b1, cfg_addr_gnt_wait, rnd[wait_width-1:0], 0);
                rnd = $urandom_range(0, wait_max);
                run_cfg(1'b1, cfg_addr_rvalid_wait, rnd[wait_width-1:0], 0);
            end
            // Random upper bits, word index kept small so reads hit known words
            addr       = $urandom();
            rnd        = $urandom_range(0, 31);
            addr[9:2]  = rnd[7:0];
            wdata      = $urandom();
            rnd        = $urandom();
            delay      = int'($urandom_range(0, max_release_delay));
            run_command(addr, rnd[8], rnd[be_width-1:0], wdata, delay);
        end
    endtask

    task automatic close_test(input string name);
        int new_errors;
        repeat (2) @(negedge clk);
        new_errors = error_count - test_errors_start;
        if (new_errors == 0) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: %0d errors", name, new_errors);
        end
        test_count++;
        test_errors_start = error_count;
    endtask

    // Counts every edge with req high and ack low, the edge where ack rises included
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_latency <= 0;
        end else if (!cmd_req_i) begin
            ack_latency <= 0;
        end else if (!cmd_ack_o) begin
            ack_latency <= ack_latency + 1;
        end
    end

    assert property (@(posedge clk) $rose(rst_n) |-> !cmd_ack_o && !cfg_ack_o)
        else report_failure("an acknowledge was high right after reset");

    // Only bytes the model has seen written are compared
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack_o) |-> (cmd_rdata_o & exp_cmd_mask) == (exp_cmd_rdata & exp_cmd_mask))
        else report_mismatch("cmd_rdata_o", exp_cmd_rdata & exp_cmd_mask,
                             cmd_rdata_o & exp_cmd_mask);

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack_o) |-> ack_latency == exp_latency + 1)
        else report_mismatch("cmd_ack_o latency", exp_latency, ack_latency - 1);

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cfg_ack_o) && !cfg_we_i |-> cfg_rdata_o == exp_cfg_rdata)
        else report_mismatch("cfg_rdata_o", {29'd0, exp_cfg_rdata}, {29'd0, cfg_rdata_o});

    assert property (@(posedge clk) disable iff (!rst_n)
        cmd_req_i && cmd_ack_o |=> cmd_ack_o)
        else report_failure("cmd_ack_o dropped while cmd_req_i was still high");

    assert property (@(posedge clk) disable iff (!rst_n)
        !cmd_req_i && cmd_ack_o |=> !cmd_ack_o)
        else report_failure("cmd_ack_o stayed high after cmd_req_i fell");

    assert property (@(posedge clk) disable iff (!rst_n)
        !cmd_req_i && !cmd_ack_o |=> !cmd_ack_o)
        else report_failure("cmd_ack_o rose without a request");

    assert property (@(posedge clk) disable iff (!rst_n)
        cfg_req_i && cfg_ack_o |=> cfg_ack_o)
        else report_failure("cfg_ack_o dropped while cfg_req_i was still high");

    assert property (@(posedge clk) disable iff (!rst_n)
        !cfg_req_i && cfg_ack_o |=> !cfg_ack_o)
        else report_failure("cfg_ack_o stayed high after cfg_req_i fell");

    assert property (@(posedge clk) disable iff (!rst_n)
        !cfg_req_i && !cfg_ack_o |=> !cfg_ack_o)
        else report_failure("cfg_ack_o rose without a request");

    initial begin
        #(timeout_cycles * clk_period_ns);
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(random_seed));
        cmd_req_i         = 1'b0;
        cmd_addr_i        = '0;
        cmd_we_i          = 1'b0;
        cmd_be_i          = '0;
        cmd_wdata_i       = '0;
        cfg_req_i         = 1'b0;
        cfg_we_i          = 1'b0;
        cfg_addr_i        = '0;
        cfg_wdata_i       = '0;
        error_count       = 0;
        test_count        = 0;
        transfer_count    = 0;
        test_errors_start = 0;
        exp_gnt_wait      = 0;
        exp_rvalid_wait   = 0;
        for (int i = 0; i < mem_words; i++) begin
            ref_mem[i]   = '0;
            ref_known[i] = '0;
        end
        wait (rst_n === 1'b1);
        @(negedge clk);

        run_cfg(1'b0, cfg_addr_gnt_wait, '0, 0);
        run_cfg(1'b0, cfg_addr_rvalid_wait, '0, 0);
        close_test("reset_defaults");

        run_command(32'h0000_0040, 1'b1, 4'hf, 32'ha5a5_1234, 0);
        run_command(32'h0000_0040, 1'b1, 4'hf, 32'h0f1e_2d3c, 0);
        run_command(32'h0000_0040, 1'b0, 4'h0, 32'h0, 0);
        run_command(32'h0000_0044, 1'b1, 4'hf, 32'hdead_beef, 1);
        run_command(32'h0000_0044, 1'b0, 4'h0, 32'h0, 0);
        close_test("full_word");

        run_command(32'h0000_0080, 1'b1, 4'hf, 32'h1122_3344, 0);
        run_command(32'h0000_0080, 1'b1, 4'b0001, 32'haaaa_aaaa, 0);
        run_command(32'h0000_0480, 1'b1, 4'b0110, 32'hbbbb_bbbb, 0);
        run_command(32'hffff_fc80, 1'b0, 4'h0, 32'h0, 0);
        run_command(32'h8000_0080, 1'b1, 4'b1000, 32'hcccc_cccc, 2);
        run_command(32'h0000_0080, 1'b1, 4'b0000, 32'hffff_ffff, 0);
        run_command(32'h0001_0080, 1'b0, 4'h0, 32'h0, 0);
        close_test("byte_enables");

        exercise_waits(3'd0, 3'd0);
        exercise_waits(3'd7, 3'd0);
        exercise_waits(3'd0, 3'd7);
        exercise_waits(3'd3, 3'd5);
        exercise_waits(3'd7, 3'd7);
        close_test("wait_states");

        run_cfg(1'b1, cfg_addr_gnt_wait, 3'd2, 5);
        run_cfg(1'b1, cfg_addr_rvalid_wait, 3'd1, 0);
        run_command(32'h0000_0200, 1'b1, 4'hf, 32'h7654_3210, 5);
        run_command(32'h0000_0200, 1'b0, 4'h0, 32'h0, 5);
        run_cfg(1'b0, cfg_addr_rvalid_wait, '0, 5);
        close_test("four_phase");

        run_random_commands(num_random_cmds);
        close_test("random_commands");

        $display("%0d tests, %0d transfers, %0d errors", test_count, transfer_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : obi_subsys_tb

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(period_ns / 2) clk_o = ~clk_o;
    end

    // Released on a falling edge, well away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (reset_cycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule : tb_clock_gen

/* source/obi_subsys_top.sv */
`timescale 1ns/1ps

module obi_subsys_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               cmd_req_i,
    input  logic [obi_pkg::addr_width-1:0]     cmd_addr_i,
    input  logic                               cmd_we_i,
    input  logic [obi_pkg::be_width-1:0]       cmd_be_i,
    input  logic [obi_pkg::data_width-1:0]     cmd_wdata_i,
    output logic                               cmd_ack_o,
    output logic [obi_pkg::data_width-1:0]     cmd_rdata_o,
    input  logic                               cfg_req_i,
    input  logic                               cfg_we_i,
    input  logic [obi_pkg::cfg_addr_width-1:0] cfg_addr_i,
    input  logic [obi_pkg::wait_width-1:0]     cfg_wdata_i,
    output logic                               cfg_ack_o,
    output logic [obi_pkg::wait_width-1:0]     cfg_rdata_o
);

    import obi_pkg::*;

    // OBI bus between bridge and memory
    logic                  obi_req;
    logic [addr_width-1:0] obi_addr;
    logic                  obi_we;
    logic [be_width-1:0]   obi_be;
    logic [data_width-1:0] obi_wdata;
    logic                  obi_gnt;
    logic                  obi_rvalid;
    logic [data_width-1:0] obi_rdata;

    logic [wait_width-1:0] gnt_wait;
    logic [wait_width-1:0] rvalid_wait;

    obi_host_bridge obi_host_bridge_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_req_i    (cmd_req_i),
        .cmd_addr_i   (cmd_addr_i),
        .cmd_we_i     (cmd_we_i),
        .cmd_be_i     (cmd_be_i),
        .cmd_wdata_i  (cmd_wdata_i),
        .cmd_ack_o    (cmd_ack_o),
        .cmd_rdata_o  (cmd_rdata_o),
        .obi_req_o    (obi_req),
        .obi_addr_o   (obi_addr),
        .obi_we_o     (obi_we),
        .obi_be_o     (obi_be),
        .obi_wdata_o  (obi_wdata),
        .obi_gnt_i    (obi_gnt),
        .obi_rvalid_i (obi_rvalid),
        .obi_rdata_i  (obi_rdata)
    );

    obi_mem obi_mem_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .obi_req_i     (obi_req),
        .obi_addr_i    (obi_addr),
        .obi_we_i      (obi_we),
        .obi_be_i      (obi_be),
        .obi_wdata_i   (obi_wdata),
        .obi_gnt_o     (obi_gnt),
        .obi_rvalid_o  (obi_rvalid),
        .obi_rdata_o   (obi_rdata),
        .gnt_wait_i    (gnt_wait),
        .rvalid_wait_i (rvalid_wait)
    );

    obi_mem_cfg obi_mem_cfg_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_req_i     (cfg_req_i),
        .cfg_we_i      (cfg_we_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .cfg_ack_o     (cfg_ack_o),
        .cfg_rdata_o   (cfg_rdata_o),
        .gnt_wait_o    (gnt_wait),
        .rvalid_wait_o (rvalid_wait)
    );

endmodule : obi_subsys_top

/* source/obi_host_bridge.sv */
`timescale 1ns/1ps

module obi_host_bridge (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cmd_req_i,
    input  logic [obi_pkg::addr_width-1:0] cmd_addr_i,
    input  logic                           cmd_we_i,
    input  logic [obi_pkg::be_width-1:0]   cmd_be_i,
    input  logic [obi_pkg::data_width-1:0] cmd_wdata_i,
    output logic                           cmd_ack_o,
    output logic [obi_pkg::data_width-1:0] cmd_rdata_o,
    output logic                           obi_req_o,
    output logic [obi_pkg::addr_width-1:0] obi_addr_o,
    output logic                           obi_we_o,
    output logic [obi_pkg::be_width-1:0]   obi_be_o,
    output logic [obi_pkg::data_width-1:0] obi_wdata_o,
    input  logic                           obi_gnt_i,
    input  logic                           obi_rvalid_i,
    input  logic [obi_pkg::data_width-1:0] obi_rdata_i
);

    import obi_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_wait_gnt,
        st_wait_rsp,
        st_ack,
        st_release
    } state_t;

    state_t state_q;

    // Control path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= st_idle;
            obi_req_o <= 1'b0;
            cmd_ack_o <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (cmd_req_i) begin
                        obi_req_o <= 1'b1;
                        state_q   <= st_wait_gnt;
                    end
                end
                st_wait_gnt: begin
                    if (obi_gnt_i) begin
                        obi_req_o <= 1'b0;
                        state_q   <= st_wait_rsp;
                    end
                end
                st_wait_rsp: begin
                    if (obi_rvalid_i) begin
                        cmd_ack_o <= 1'b1;
                        state_q   <= st_ack;
                    end
                end
                st_ack: begin
                    // Held here until the host lets go of req
                    if (!cmd_req_i) begin
                        cmd_ack_o <= 1'b0;
                        state_q   <= st_release;
                    end
                end
                st_release: begin
                    state_q <= st_idle;
                end
                default: begin
                    obi_req_o <= 1'b0;
                    cmd_ack_o <= 1'b0;
                    state_q   <= st_idle;
                end
            endcase
        end
    end

    // Address phase payload, latched once per command
    always_ff @(posedge clk) begin
        if (state_q == st_idle && cmd_req_i) begin
            obi_addr_o  <= cmd_addr_i;
            obi_we_o    <= cmd_we_i;
            obi_be_o    <= cmd_be_i;
            obi_wdata_o <= cmd_wdata_i;
        end
    end

    // Read data stays valid for the whole ack phase
    always_ff @(posedge clk) begin
        if (state_q == st_wait_rsp && obi_rvalid_i) begin
            cmd_rdata_o <= obi_rdata_i;
        end
    end

    // Address phase may not change or drop before the grant
    assert property (@(posedge clk) disable iff (!rst_n)
        obi_req_o && !obi_gnt_i |=> obi_req_o &&
            $stable({obi_addr_o, obi_we_o, obi_be_o, obi_wdata_o}))
        else $error("obi address phase changed before grant");

    assert property (@(posedge clk) disable iff (!rst_n)
        obi_rvalid_i |-> state_q == st_wait_rsp)
        else $error("obi_rvalid_i outside the response phase");

endmodule : obi_host_bridge

/* obi_mem/obi_mem_cfg.sv */
`timescale 1ns/1ps

module obi_mem_cfg (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               cfg_req_i,
    input  logic                               cfg_we_i,
    input  logic [obi_pkg::cfg_addr_width-1:0] cfg_addr_i,
    input  logic [obi_pkg::wait_width-1:0]     cfg_wdata_i,
    output logic                               cfg_ack_o,
    output logic [obi_pkg::wait_width-1:0]     cfg_rdata_o,
    output logic [obi_pkg::wait_width-1:0]     gnt_wait_o,
    output logic [obi_pkg::wait_width-1:0]     rvalid_wait_o
);

    import obi_pkg::*;

    logic                  access;
    logic [wait_width-1:0] gnt_wait_q;
    logic [wait_width-1:0] rvalid_wait_q;
    logic [wait_width-1:0] reg_rd;

    // New request seen while idle
    assign access = cfg_req_i && !cfg_ack_o;

    always_comb begin
        case (cfg_addr_i)
            cfg_addr_gnt_wait:    reg_rd = gnt_wait_q;
            cfg_addr_rvalid_wait: reg_rd = rvalid_wait_q;
            default:              reg_rd = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_ack_o     <= 1'b0;
            gnt_wait_q    <= '0;
            rvalid_wait_q <= '0;
        end else if (access) begin
            cfg_ack_o <= 1'b1;
            if (cfg_we_i) begin
                case (cfg_addr_i)
                    cfg_addr_gnt_wait:    gnt_wait_q    <= cfg_wdata_i;
                    cfg_addr_rvalid_wait: rvalid_wait_q <= cfg_wdata_i;
                    default: ;
                endcase
            end
        end else if (cfg_ack_o && !cfg_req_i) begin
            cfg_ack_o <= 1'b0;
        end
    end

    // A write reads back the value it stored
    always_ff @(posedge clk) begin
        if (access) begin
            cfg_rdata_o <= cfg_we_i ? cfg_wdata_i : reg_rd;
        end
    end

    assign gnt_wait_o    = gnt_wait_q;
    assign rvalid_wait_o = rvalid_wait_q;

endmodule : obi_mem_cfg

/* obi_mem/obi_mem.sv */
`timescale 1ns/1ps

module obi_mem (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           obi_req_i,
    input  logic [obi_pkg::addr_width-1:0] obi_addr_i,
    input  logic                           obi_we_i,
    input  logic [obi_pkg::be_width-1:0]   obi_be_i,
    input  logic [obi_pkg::data_width-1:0] obi_wdata_i,
    output logic                           obi_gnt_o,
    output logic                           obi_rvalid_o,
    output logic [obi_pkg::data_width-1:0] obi_rdata_o,
    input  logic [obi_pkg::wait_width-1:0] gnt_wait_i,
    input  logic [obi_pkg::wait_width-1:0] rvalid_wait_i
);

    import obi_pkg::*;

    logic [data_width-1:0]      mem_q [mem_words];
    logic [mem_index_width-1:0] word_idx;
    logic [data_width-1:0]      old_word;
    logic [data_width-1:0]      merged_word;

    logic                  addr_busy_q;
    logic [wait_width-1:0] gnt_wait_q;
    logic [wait_width-1:0] rvalid_wait_q;
    logic [wait_width-1:0] gnt_cnt_q;
    logic [wait_width-1:0] gnt_limit;
    logic [wait_width-1:0] rsp_limit;
    logic                  rsp_pending_q;
    logic [wait_width-1:0] rsp_cnt_q;

    // Upper address bits are ignored, so the memory wraps
    assign word_idx = obi_addr_i[mem_index_lsb +: mem_index_width];
    assign old_word = mem_q[word_idx];

    always_comb begin
        merged_word = old_word;
        for (int b = 0; b < be_width; b++) begin
            if (obi_be_i[b]) begin
                merged_word[b*8 +: 8] = obi_wdata_i[b*8 +: 8];
            end
        end
    end

    // Waits are taken on the first request cycle and kept for the transaction
    assign gnt_limit = addr_busy_q ? gnt_wait_q : gnt_wait_i;
    assign rsp_limit = addr_busy_q ? rvalid_wait_q : rvalid_wait_i;

    assign obi_gnt_o = obi_req_i && (gnt_cnt_q == gnt_limit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_busy_q   <= 1'b0;
            gnt_wait_q    <= '0;
            rvalid_wait_q <= '0;
            gnt_cnt_q     <= '0;
        end else if (obi_gnt_o) begin
            addr_busy_q <= 1'b0;
            gnt_cnt_q   <= '0;
        end else if (obi_req_i) begin
            addr_busy_q <= 1'b1;
            if (!addr_busy_q) begin
                gnt_wait_q    <= gnt_wait_i;
                rvalid_wait_q <= rvalid_wait_i;
            end
            if (gnt_cnt_q != gnt_limit) begin
                gnt_cnt_q <= gnt_cnt_q + 1'b1;
            end
        end
    end

    // Response delay
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_pending_q <= 1'b0;
            rsp_cnt_q     <= '0;
            obi_rvalid_o  <= 1'b0;
        end else begin
            obi_rvalid_o <= rsp_pending_q && (rsp_cnt_q == '0);
            if (obi_gnt_o) begin
                rsp_pending_q <= 1'b1;
                rsp_cnt_q     <= rsp_limit;
            end else if (rsp_pending_q) begin
                if (rsp_cnt_q == '0) begin
                    rsp_pending_q <= 1'b0;
                end else begin
                    rsp_cnt_q <= rsp_cnt_q - 1'b1;
                end
            end
        end
    end

    // Read before write, the response carries the old word
    always_ff @(posedge clk) begin
        if (obi_gnt_o) begin
            obi_rdata_o <= old_word;
            if (obi_we_i) begin
                mem_q[word_idx] <= merged_word;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        obi_gnt_o |-> !rsp_pending_q && !obi_rvalid_o)
        else $error("grant while a response was pending");

endmodule : obi_mem

/* common/obi_pkg.sv */
package obi_pkg;

    // OBI bus widths
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int be_width   = data_width / 8;

    // Subordinate memory geometry
    localparam int mem_words       = 256;
    localparam int mem_index_width = $clog2(mem_words);

    // Lowest address bit of the word index, bytes within a word sit below it
    localparam int mem_index_lsb = $clog2(be_width);

    // Wait-state fields of the configuration block
    localparam int wait_width = 3;
    localparam int wait_max   = (1 << wait_width) - 1;

    // Configuration register map
    localparam int cfg_addr_width = 1;
    localparam logic [cfg_addr_width-1:0] cfg_addr_gnt_wait    = 1'b0;
    localparam logic [cfg_addr_width-1:0] cfg_addr_rvalid_wait = 1'b1;

endpackage : obi_pkg
